//--- flist.f
+incdir+.
mr_pkg.sv
mr_status_decode.sv
mr_sync_shift.sv
mr_dwnld.sv
mr_frame_top.sv
tb_mr_frame.sv

//--- Makefile
# Verilator flow for the frame glue testbench

TOP := tb_mr_frame

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q -F "Simulation passed"

clean:
	rm -rf obj_dir

//--- tb_mr_frame.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the frame glue: stimulus, reference models, assertions
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "mr_defines.svh"

module tb_mr_frame import mr_pkg::*; ();

    localparam int MAX_CYCLES = 4000;
    localparam int LINE_LEN   = 12;

    logic                   clk_sys  = 1'b0;
    logic                   rst_n    = 1'b0;
    mr_status_t             status   = '0;
    logic [1:0]             rotate   = 2'd0;
    mr_hps_t                hps      = '0;
    logic                   prog_rdy = 1'b0;
    logic                   pxl_cen  = 1'b0;
    mr_sync_t               sync_in  = '0;
    logic                   hps_wait;
    mr_ioctl_t              ioctl;
    logic                   downloading;
    logic [`MR_DIPSW_W-1:0] dipsw;
    mr_osd_t                osd;
    logic [`MR_MENU_W-1:0]  menumask;
    mr_sync_t               sync_out;

    // Reference model state
    mr_osd_t                exp_osd;
    logic [`MR_MENU_W-1:0]  exp_mask;
    logic [6:0]             exp_mod;
    logic [`MR_DIPSW_W-1:0] exp_dipsw;
    mr_ioctl_t              exp_ioctl;
    logic                   exp_wait;
    logic                   exp_dl;
    mr_sync_t               exp_sync;
    // Bit k holds the sample taken k+1 pixel ticks (or lines) ago
    logic [14:0]            hs_past;
    logic [14:0]            vs_past;

    int unsigned cycles      = 0;
    int unsigned rom_writes  = 0;
    int unsigned rom_pulses  = 0;
    int unsigned rdy_delay   = 0;
    int unsigned rdy_draw    = 0;
    logic        rdy_pending = 1'b0;
    int unsigned pix         = 0;

    mr_frame_top u_dut (.*);

    always #20 clk_sys = ~clk_sys;

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic value_error(input string msg);
        abort_run($sformatf("ERR %0t: %s", $time, msg));
    endtask

    task automatic set_download(input logic on, input logic [7:0] index);
        @(posedge clk_sys);
        hps.download <= on;
        hps.index    <= index;
    endtask

    // One host write held off while the DUT asks to wait
    task automatic host_write(input logic [7:0] index, input logic [`MR_ADDR_W-1:0] addr,
                              input logic [7:0] data);
        @(posedge clk_sys);
        while (hps_wait) begin
            @(posedge clk_sys);
        end
        hps.wr    <= 1'b1;
        hps.index <= index;
        hps.addr  <= addr;
        hps.dout  <= data;
        if (index == `MR_IDX_ROM) begin
            rom_writes++;
        end
        @(posedge clk_sys);
        hps.wr <= 1'b0;
    endtask

    function automatic mr_osd_t osd_model(input logic [63:0] w, input logic [6:0] mode,
                                          input logic [1:0] rot);
        mr_osd_t o;
        o.hsize_enable   = w[19];
        o.hsize_scale    = w[23:20];
        o.hoffset        = w[27:24];
        o.voffset        = w[31:28];
        o.shadowmask     = w[34:32];
        o.shadowmask_2x  = w[35];
        o.shadowmask_rot = w[36] ^ (mode[0] & rot[0]);
        o.db15_en        = w[37];
        return o;
    endfunction

    function automatic logic [`MR_MENU_W-1:0] mask_model(input logic [63:0] w,
                                                          input logic [6:0] mode);
        logic [`MR_MENU_W-1:0] m;
        m    = '0;
        m[3] = (w[34:32] == 3'd0);
        m[2] = !w[19];
        m[1] = !mode[0];
        return m;
    endfunction

    function automatic logic tap_pick(input logic now, input logic [14:0] past,
                                      input logic [3:0] ago);
        if (ago == 4'd0) begin
            return now;
        end
        return past[ago - 4'd1];
    endfunction

    // Status decode and download models
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            exp_osd   <= '0;
            exp_mask  <= '0;
            exp_mod   <= '0;
            exp_dipsw <= '0;
            exp_ioctl <= '0;
            exp_wait  <= 1'b0;
            exp_dl    <= 1'b0;
        end else begin
            exp_osd  <= osd_model(status.raw, exp_mod, rotate);
            exp_mask <= mask_model(status.raw, exp_mod);
            if (hps.wr && hps.index == `MR_IDX_MOD && hps.addr == '0) begin
                exp_mod <= hps.dout[6:0];
            end
            if (hps.wr && hps.index == `MR_IDX_DIP && hps.addr < 27'd4) begin
                exp_dipsw[8 * hps.addr[1:0] +: 8] <= hps.dout;
            end
            exp_ioctl.rom_wr <= hps.download && hps.index == `MR_IDX_ROM && hps.wr;
            exp_ioctl.ram    <= hps.download && hps.index == `MR_IDX_NVRAM;
            if (hps.download && hps.index == `MR_IDX_ROM && hps.wr) begin
                exp_ioctl.addr <= hps.addr;
                exp_ioctl.dout <= hps.dout;
                exp_wait       <= 1'b1;
            end else if (prog_rdy) begin
                exp_wait <= 1'b0;
            end
            if (hps.download) begin
                exp_dl <= 1'b1;
            end else if (!exp_wait) begin
                exp_dl <= 1'b0;
            end
        end
    end

    // Sync shift model
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            hs_past  <= '0;
            vs_past  <= '0;
            exp_sync <= '0;
        end else if (pxl_cen) begin
            exp_sync.hs   <= tap_pick(sync_in.hs, hs_past, exp_osd.hoffset);
            exp_sync.lhbl <= sync_in.lhbl;
            exp_sync.lvbl <= sync_in.lvbl;
            hs_past       <= {hs_past[13:0], sync_in.hs};
            // New line when hs goes high
            if (sync_in.hs && !hs_past[0]) begin
                exp_sync.vs <= tap_pick(sync_in.vs, vs_past, exp_osd.voffset);
                vs_past     <= {vs_past[13:0], sync_in.vs};
            end
        end
    end

    a_osd: assert property (@(posedge clk_sys) disable iff (!rst_n)
        osd == exp_osd && menumask == exp_mask)
        else value_error("osd or menumask does not follow the status word");
    a_rom: assert property (@(posedge clk_sys) disable iff (!rst_n)
        ioctl.rom_wr == exp_ioctl.rom_wr && ioctl.ram == exp_ioctl.ram
        && (!exp_ioctl.rom_wr || (ioctl.addr == exp_ioctl.addr
        && ioctl.dout == exp_ioctl.dout)))
        else value_error("ioctl write or ram flag differs from the host stream");
    a_wait: assert property (@(posedge clk_sys) disable iff (!rst_n)
        hps_wait == exp_wait && downloading == exp_dl)
        else value_error("hps_wait or downloading outside its window");
    a_dip: assert property (@(posedge clk_sys) disable iff (!rst_n) dipsw == exp_dipsw)
        else value_error("dipsw differs from the written bytes");
    a_hs: assert property (@(posedge clk_sys) disable iff (!rst_n) sync_out.hs == exp_sync.hs)
        else value_error("sync_out.hs is not the hoffset tap");
    a_vs: assert property (@(posedge clk_sys) disable iff (!rst_n) sync_out.vs == exp_sync.vs)
        else value_error("sync_out.vs is not the voffset line tap");
    a_blank: assert property (@(posedge clk_sys) disable iff (!rst_n)
        sync_out.lhbl == exp_sync.lhbl && sync_out.lvbl == exp_sync.lvbl)
        else value_error("blanking is not the previous pixel sample");

    // Memory side answers each ROM write after 0 to 5 idle cycles
    always @(posedge clk_sys) begin
        prog_rdy <= 1'b0;
        if (ioctl.rom_wr) begin
            rdy_draw = $urandom_range(5, 0);
            if (rdy_draw == 0) begin
                prog_rdy <= 1'b1;
            end else begin
                rdy_delay   <= rdy_draw - 1;
                rdy_pending <= 1'b1;
            end
        end else if (rdy_pending && rdy_delay == 0) begin
            prog_rdy    <= 1'b1;
            rdy_pending <= 1'b0;
        end else if (rdy_pending) begin
            rdy_delay <= rdy_delay - 1;
        end
    end

    // Line pattern advances only on pixels the DUT takes
    always @(posedge clk_sys) begin
        pxl_cen <= ($urandom_range(1, 0) == 1);
        if (pxl_cen) begin
            sync_in.hs   <= pix < 3;
            sync_in.lhbl <= pix >= 4;
            if (pix == 0) begin
                sync_in.vs   <= ($urandom_range(3, 0) == 0);
                sync_in.lvbl <= ($urandom_range(7, 0) != 0);
            end
            pix <= (pix == LINE_LEN - 1) ? 0 : pix + 1;
        end
    end

    always @(posedge clk_sys) begin
        cycles++;
        if (ioctl.rom_wr) begin
            rom_pulses++;
        end
        if (cycles == MAX_CYCLES) begin
            abort_run("Timeout: the tests did not finish within 4000 clock cycles");
        end
    end

    initial begin
        void'($urandom(32'hadcf));
        repeat (5) @(posedge clk_sys);
        rst_n <= 1'b1;
        @(negedge clk_sys);
        a_reset: assert (!ioctl.rom_wr && !ioctl.ram && !hps_wait && !downloading
                         && osd == '0 && menumask == '0 && dipsw == '0 && sync_out == '0)
            else value_error("outputs not zero right after reset");
        // Core mode bit 0 against every rotate value
        for (int m = 0; m < 2; m++) begin
            set_download(1'b1, `MR_IDX_MOD);
            host_write(`MR_IDX_MOD, '0, {7'($urandom), m[0]});
            set_download(1'b0, `MR_IDX_MOD);
            for (int r = 0; r < 4; r++) begin
                rotate <= r[1:0];
                repeat (40) begin
                    @(posedge clk_sys);
                    status.raw <= {$urandom, $urandom};
                end
            end
        end
        set_download(1'b1, `MR_IDX_ROM);
        repeat (80) begin
            host_write(`MR_IDX_ROM, 27'($urandom), 8'($urandom));
        end
        set_download(1'b0, `MR_IDX_ROM);
        set_download(1'b1, `MR_IDX_DIP);
        for (int b = 0; b < 4; b++) begin
            host_write(`MR_IDX_DIP, 27'(b), 8'($urandom));
        end
        set_download(1'b0, `MR_IDX_DIP);
        set_download(1'b1, `MR_IDX_NVRAM);
        repeat (10) @(posedge clk_sys);
        set_download(1'b0, `MR_IDX_NVRAM);
        // Random offsets while the line pattern runs
        repeat (6) begin
            @(posedge clk_sys);
            status.raw <= {$urandom, $urandom};
            repeat (120) @(posedge clk_sys);
        end
        repeat (5) @(posedge clk_sys);
        if (rom_pulses != rom_writes) begin
            value_error($sformatf("%0d rom_wr pulses for %0d host ROM writes",
                                  rom_pulses, rom_writes));
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

//--- mr_frame_top.sv
////////////////////////////////////////////////////////////////////////////
// Frame glue top: status decode, sync shift and download routing
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "mr_defines.svh"

module mr_frame_top import mr_pkg::*; (
    input  logic                   clk_sys,
    input  logic                   rst_n,
    // OSD
    input  mr_status_t             status,
    input  logic [1:0]             rotate,
    // Host download
    input  mr_hps_t                hps,
    output logic                   hps_wait,
    // ROM programming
    output mr_ioctl_t              ioctl,
    input  logic                   prog_rdy,
    output logic                   downloading,
    output logic [`MR_DIPSW_W-1:0] dipsw,
    // Decoded settings
    output mr_osd_t                osd,
    output logic [`MR_MENU_W-1:0]  menumask,
    // Base video sync
    input  logic                   pxl_cen,
    input  mr_sync_t               sync_in,
    output mr_sync_t               sync_out
);

    logic [`MR_CORE_MOD_W-1:0] core_mod;

    mr_status_decode u_status (
        .clk_sys   ( clk_sys     ),
        .rst_n     ( rst_n       ),
        .status    ( status      ),
        .core_mod  ( core_mod    ),
        .rotate    ( rotate      ),
        .osd       ( osd         ),
        .menumask  ( menumask    )
    );

    // Offsets come from the registered settings
    mr_sync_shift u_sync (
        .clk_sys   ( clk_sys     ),
        .rst_n     ( rst_n       ),
        .pxl_cen   ( pxl_cen     ),
        .sync_in   ( sync_in     ),
        .hoffset   ( osd.hoffset ),
        .voffset   ( osd.voffset ),
        .sync_out  ( sync_out    )
    );

    mr_dwnld u_dwnld (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .hps         ( hps         ),
        .hps_wait    ( hps_wait    ),
        .ioctl       ( ioctl       ),
        .prog_rdy    ( prog_rdy    ),
        .downloading ( downloading ),
        .core_mod    ( core_mod    ),
        .dipsw       ( dipsw       )
    );

endmodule

//--- mr_dwnld.sv
////////////////////////////////////////////////////////////////////////////
// Host download routing: ROM writes with wait, core mode, DIP and NVRAM
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "mr_defines.svh"

module mr_dwnld import mr_pkg::*; (
    input  logic                      clk_sys,
    input  logic                      rst_n,
    input  mr_hps_t                   hps,
    output logic                      hps_wait,
    output mr_ioctl_t                 ioctl,
    input  logic                      prog_rdy,
    output logic                      downloading,
    output logic [`MR_CORE_MOD_W-1:0] core_mod,
    output logic [`MR_DIPSW_W-1:0]    dipsw
);

    logic                  rom_sel;
    logic                  rom_wr_nx;
    logic                  mod_wr;
    logic                  dip_wr;
    logic                  nvram_sel;
    logic                  rom_wr_q;
    logic                  ram_q;
    logic [`MR_ADDR_W-1:0] addr_q;
    logic [`MR_DATA_W-1:0] dout_q;

    // Index decode
    assign rom_sel   = hps.download && hps.index == `MR_IDX_ROM;
    assign nvram_sel = hps.download && hps.index == `MR_IDX_NVRAM;
    assign rom_wr_nx = rom_sel && hps.wr;

    // Configuration bytes sit at the start of their index
    assign mod_wr = hps.wr && hps.index == `MR_IDX_MOD && hps.addr == '0;
    assign dip_wr = hps.wr && hps.index == `MR_IDX_DIP
                    && hps.addr[`MR_ADDR_W-1:2] == '0;

    // Pending ROM write payload
    always_ff @(posedge clk_sys) begin
        if (rom_wr_nx) begin
            addr_q <= hps.addr;
            dout_q <= hps.dout;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            rom_wr_q <= 1'b0;
            hps_wait <= 1'b0;
            ram_q    <= 1'b0;
        end else begin
            rom_wr_q <= rom_wr_nx;
            ram_q    <= nvram_sel;
            // Host stays stalled until the memory takes the byte
            if (rom_wr_nx) begin
                hps_wait <= 1'b1;
            end else if (prog_rdy) begin
                hps_wait <= 1'b0;
            end
        end
    end

    // Window stays open while a ROM write is still in flight
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            downloading <= 1'b0;
        end else begin
            downloading <= hps.download | hps_wait;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            core_mod <= '0;
            dipsw    <= '0;
        end else begin
            if (mod_wr) begin
                core_mod <= hps.dout[`MR_CORE_MOD_W-1:0];
            end
            // One DIP byte per address, little endian
            if (dip_wr) begin
                dipsw[{hps.addr[1:0], 3'b000} +: 8] <= hps.dout;
            end
        end
    end

    assign ioctl = '{rom_wr: rom_wr_q, ram: ram_q, addr: addr_q, dout: dout_q};

endmodule

//--- mr_sync_shift.sv
////////////////////////////////////////////////////////////////////////////
// Sync position shift by OSD offsets, with blanking kept in step
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "mr_defines.svh"

module mr_sync_shift import mr_pkg::*; (
    input  logic       clk_sys,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  mr_sync_t   sync_in,
    input  logic [3:0] hoffset,
    input  logic [3:0] voffset,
    output mr_sync_t   sync_out
);

    localparam int DEPTH = `MR_OFFSET_DEPTH;

    // Past samples only, tap 0 of each chain is the live input
    logic [DEPTH-2:0] hs_hist;
    logic [DEPTH-2:0] vs_hist;
    logic [DEPTH-1:0] hs_taps;
    logic [DEPTH-1:0] vs_taps;
    logic             hs_rise;

    assign hs_taps = {hs_hist, sync_in.hs};
    assign vs_taps = {vs_hist, sync_in.vs};

    // hs_hist[0] holds hs from the previous pixel
    assign hs_rise = pxl_cen & sync_in.hs & ~hs_hist[0];

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            hs_hist  <= '0;
            vs_hist  <= '0;
            sync_out <= '0;
        end else begin
            // Horizontal chain advances once per pixel
            if (pxl_cen) begin
                hs_hist       <= hs_taps[DEPTH-2:0];
                sync_out.hs   <= hs_taps[hoffset];
                sync_out.lhbl <= sync_in.lhbl;
                sync_out.lvbl <= sync_in.lvbl;
            end
            // Vertical chain advances once per line
            if (hs_rise) begin
                vs_hist     <= vs_taps[DEPTH-2:0];
                sync_out.vs <= vs_taps[voffset];
            end
        end
    end

endmodule

//--- mr_status_decode.sv
////////////////////////////////////////////////////////////////////////////
// OSD status decode into registered settings and menu mask
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "mr_defines.svh"

module mr_status_decode import mr_pkg::*; (
    input  logic                      clk_sys,
    input  logic                      rst_n,
    input  mr_status_t                status,
    input  logic [`MR_CORE_MOD_W-1:0] core_mod,
    input  logic [1:0]                rotate,
    output mr_osd_t                   osd,
    output logic [`MR_MENU_W-1:0]     menumask
);

    mr_status_fields_t     st;
    mr_osd_t               osd_nx;
    logic [`MR_MENU_W-1:0] mask_nx;

    assign st = status.fields;

    always_comb begin
        osd_nx.hsize_enable  = st.hsize_enable;
        osd_nx.hsize_scale   = st.hsize_scale;
        osd_nx.hoffset       = st.hoffset;
        osd_nx.voffset       = st.voffset;
        osd_nx.shadowmask    = st.shadowmask;
        osd_nx.shadowmask_2x = st.shadowmask_2x;
        osd_nx.db15_en       = st.db15_en;
        // Vertical game on a rotated screen flips the mask, OSD can flip it back
        osd_nx.shadowmask_rot = st.rot_flip ^ (core_mod[0] & rotate[0]);
    end

    // A high bit hides the menu item
    always_comb begin
        mask_nx    = '0;
        // Shadow mask filter
        mask_nx[3] = st.shadowmask == 3'd0;
        // Horizontal scaling
        mask_nx[2] = ~st.hsize_enable;
        // Vertical game
        mask_nx[1] = ~core_mod[0];
        // bit 0 is direct video, never shown here
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            osd      <= '0;
            menumask <= '0;
        end else begin
            osd      <= osd_nx;
            menumask <= mask_nx;
        end
    end

endmodule

//--- mr_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types: status word union, OSD settings, sync and download buses
////////////////////////////////////////////////////////////////////////////
`include "mr_defines.svh"

package mr_pkg;

    // Status bits laid out from the top of the word down
    typedef struct packed {
        logic [`MR_ST_HI_W-1:0] unused_hi;
        logic                   db15_en;
        logic                   rot_flip;
        logic                   shadowmask_2x;
        logic [2:0]             shadowmask;
        logic [3:0]             voffset;
        logic [3:0]             hoffset;
        logic [3:0]             hsize_scale;
        logic                   hsize_enable;
        logic [`MR_ST_LO_W-1:0] unused_lo;
    } mr_status_fields_t;

    // Same word, either flat for the menu or as typed settings
    typedef union packed {
        logic [`MR_STATUS_W-1:0] raw;
        mr_status_fields_t       fields;
    } mr_status_t;

    typedef struct packed {
        logic       hsize_enable;
        logic [3:0] hsize_scale;
        logic [3:0] hoffset;
        logic [3:0] voffset;
        logic [2:0] shadowmask;
        logic       shadowmask_2x;
        logic       shadowmask_rot;
        logic       db15_en;
    } mr_osd_t;

    typedef struct packed {
        logic hs;
        logic vs;
        logic lhbl;
        logic lvbl;
    } mr_sync_t;

    // Host side of the download stream
    typedef struct packed {
        logic                   download;
        logic                   wr;
        logic [`MR_INDEX_W-1:0] index;
        logic [`MR_ADDR_W-1:0]  addr;
        logic [`MR_DATA_W-1:0]  dout;
    } mr_hps_t;

    // ROM write side towards the memory
    typedef struct packed {
        logic                  rom_wr;
        logic                  ram;
        logic [`MR_ADDR_W-1:0] addr;
        logic [`MR_DATA_W-1:0] dout;
    } mr_ioctl_t;

endpackage

//--- mr_defines.svh
////////////////////////////////////////////////////////////////////////////
// Widths, download indexes and status word layout for the frame glue
////////////////////////////////////////////////////////////////////////////
`ifndef MR_DEFINES_SVH
`define MR_DEFINES_SVH

// OSD status word and the padding around its decoded fields
`define MR_STATUS_W      64
`define MR_ST_LO_W       19
`define MR_ST_HI_W       26

// Host download indexes
`define MR_IDX_ROM       8'd0
`define MR_IDX_MOD       8'd1
`define MR_IDX_NVRAM     8'd2
`define MR_IDX_DIP       8'd254

// Download bus
`define MR_INDEX_W       8
`define MR_ADDR_W        27
`define MR_DATA_W        8

// Configuration outputs
`define MR_CORE_MOD_W    7
`define MR_DIPSW_W       32
`define MR_MENU_W        16

// Sync delay taps, current sample included
`define MR_OFFSET_DEPTH  16

`endif
